// File: Makefile
VERILATOR  = verilator
FILELIST   = hps_link.f
DUT_TOP    = hps_link
TB_TOP     = hps_link_tb
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hps_link.f
+incdir+hw
hw/hps_link_pkg.sv
hw/uio_word_if.sv
hw/uio_sequencer.sv
hw/input_regs.sv
hw/ps2_key_decode.sv
hw/ioctl_addr_counter.sv
hw/file_transfer.sv
hw/hps_link.sv
verification/hps_link_tb.sv

// File: hw/file_transfer.sv
//////////////////////////////////////////////////////////////////////
// file-io FSM, download into and upload from core memory
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "hps_link_defines.svh"

module file_transfer (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   fp_enable,
	input  logic                   io_strobe,
	input  logic [`HPS_WORD_W-1:0] io_din,
	input  logic [`HPS_DATA_W-1:0] ioctl_din,
	output logic                   ioctl_download,
	output logic                   ioctl_upload,
	output logic [15:0]            ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output logic [`HPS_ADDR_W-1:0] ioctl_addr,
	output logic [`HPS_DATA_W-1:0] ioctl_dout,
	output logic                   ioctl_wr,
	output logic                   ioctl_rd,
	output logic [`HPS_WORD_W-1:0] fp_dout
);
	typedef enum logic [1:0] {
		F_IDLE,
		F_CMD,
		F_DATA
	} fio_state_t;

	fio_state_t state;
	logic [7:0] cmd;
	logic [2:0] cnt;
	logic       wr_pend;
	logic       cmd_word;
	logic       word_stb;
	logic       tx_word;
	logic       dat_word;
	logic       start_ul;
	logic       start_dl;
	logic       stop;
	logic       step_dl;
	logic       step_ul;

	assign cmd_word = fp_enable & io_strobe & (state != F_DATA);
	assign word_stb = fp_enable & io_strobe & (state == F_DATA);
	assign tx_word  = word_stb & (cmd == `FIO_TX);
	assign dat_word = word_stb & (cmd == `FIO_TX_DAT);

	// first transfer word selects upload, download or end
	assign start_ul = tx_word & (cnt == 3'd0) & (io_din[7:0] == `FIO_UPLOAD_KEY);
	assign start_dl = tx_word & (cnt == 3'd0) & (io_din[7:0] != 8'h00) &
		(io_din[7:0] != `FIO_UPLOAD_KEY);
	assign stop     = tx_word & (cnt == 3'd0) & (io_din[7:0] == 8'h00);
	assign step_dl  = dat_word & ioctl_download;
	assign step_ul  = dat_word & ~ioctl_download;

	ioctl_addr_counter u_addr (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.load_lo    (tx_word & (cnt == 3'd1)),
		.load_hi    (tx_word & (cnt == 3'd2)),
		.load_val   (io_din),
		.clear      (start_ul | start_dl),
		.step_dl    (step_dl),
		.step_ul    (step_ul),
		.publish    (stop & ioctl_download),
		.ioctl_addr (ioctl_addr)
	);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state          <= F_IDLE;
			cmd            <= 8'h00;
			cnt            <= 3'd0;
			wr_pend        <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_rd       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_upload   <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_dout     <= '0;
			fp_dout        <= '0;
		end else begin
			// write pulse trails the data word by two cycles
			wr_pend  <= step_dl;
			ioctl_wr <= wr_pend;
			ioctl_rd <= start_ul | step_ul;

			if (!fp_enable) state <= F_IDLE;
			else if (cmd_word) state <= F_DATA;
			else if (state == F_IDLE) state <= F_CMD;

			if (cmd_word) begin
				cmd <= (io_din[15:8] == 8'h00) ? io_din[7:0] : 8'h00;
				cnt <= 3'd0;
			end else if (word_stb) begin
				case (cmd)
					`FIO_INFO: begin
						// extension arrives high half first
						if (cnt == 3'd0) ioctl_file_ext[31:16] <= io_din;
						if (cnt == 3'd1) ioctl_file_ext[15:0] <= io_din;
						if (!cnt[1]) cnt <= cnt + 1'b1;
					end
					`FIO_INDEX: ioctl_index <= io_din;
					`FIO_TX: if (cnt != 3'd7) cnt <= cnt + 1'b1;
					default: ;
				endcase
			end

			if (start_ul) ioctl_upload <= 1'b1;
			if (start_dl) ioctl_download <= 1'b1;
			if (stop) begin
				ioctl_download <= 1'b0;
				ioctl_upload   <= 1'b0;
			end
			if (step_dl) ioctl_dout <= io_din[`HPS_DATA_W-1:0];
			if (step_ul) fp_dout <= {{(`HPS_WORD_W-`HPS_DATA_W){1'b0}}, ioctl_din};
		end
	end

endmodule

// File: hw/hps_link.sv
//////////////////////////////////////////////////////////////////////
// host link top, user-io and file-io blocks behind plain ports
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "hps_link_defines.svh"

module hps_link (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   io_enable,
	input  logic                   fp_enable,
	input  logic                   io_strobe,
	input  logic [`HPS_WORD_W-1:0] io_din,
	input  logic [63:0]            status_in,
	input  logic                   status_set,
	input  logic [`HPS_DATA_W-1:0] ioctl_din,
	input  logic                   ioctl_wait,
	output logic [`HPS_WORD_W-1:0] io_dout,
	output logic                   hps_wait,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic                   direct_video,
	output logic [31:0]            joystick_0,
	output logic [31:0]            joystick_1,
	output logic [31:0]            joystick_2,
	output logic [31:0]            joystick_3,
	output logic [63:0]            status,
	output logic [10:0]            ps2_key,
	output logic                   ioctl_download,
	output logic                   ioctl_upload,
	output logic [15:0]            ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output logic [`HPS_ADDR_W-1:0] ioctl_addr,
	output logic [`HPS_DATA_W-1:0] ioctl_dout,
	output logic                   ioctl_wr,
	output logic                   ioctl_rd
);
	import hps_link_pkg::*;

	logic [`HPS_WORD_W-1:0] uio_dout;
	logic [`HPS_WORD_W-1:0] fp_dout;
	logic [`HPS_WORD_W-1:0] cfg_word;
	key_event_t             key_evt;

	uio_word_if uio ();

	uio_sequencer u_seq (
		.clk_sys(clk_sys), .rst(rst), .io_enable(io_enable), .io_strobe(io_strobe),
		.io_din(io_din), .uio(uio.seq), .uio_dout(uio_dout)
	);

	input_regs u_regs (
		.clk_sys(clk_sys), .rst(rst), .status_in(status_in), .status_set(status_set),
		.uio(uio.regs), .cfg_word(cfg_word), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .joystick_2(joystick_2), .joystick_3(joystick_3),
		.status(status)
	);

	ps2_key_decode u_kbd (.clk_sys(clk_sys), .rst(rst), .uio(uio.key), .ps2_key(key_evt));

	file_transfer u_fio (
		.clk_sys(clk_sys), .rst(rst), .fp_enable(fp_enable), .io_strobe(io_strobe),
		.io_din(io_din), .ioctl_din(ioctl_din), .ioctl_download(ioctl_download),
		.ioctl_upload(ioctl_upload), .ioctl_index(ioctl_index),
		.ioctl_file_ext(ioctl_file_ext), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_wr(ioctl_wr), .ioctl_rd(ioctl_rd), .fp_dout(fp_dout)
	);

	// config word fields used by the core
	assign buttons            = cfg_word[1:0];
	assign forced_scandoubler = cfg_word[4];
	assign direct_video       = cfg_word[10];

	assign ps2_key  = key_evt;
	assign io_dout  = fp_enable ? fp_dout : uio_dout;
	// memory stalls go straight back to the host
	assign hps_wait = ioctl_wait;

endmodule

// File: hw/hps_link_defines.svh
//////////////////////////////////////////////////////////////////////
// widths, counts and command codes of the host link
//////////////////////////////////////////////////////////////////////
`ifndef HPS_LINK_DEFINES_SVH
`define HPS_LINK_DEFINES_SVH

`define HPS_WORD_W      16
`define HPS_IDX_W       4
`define HPS_JOY_N       4
`define HPS_ADDR_W      27
`define HPS_DATA_W      8
`define HPS_ADDR_STEP   1

// user-io commands
`define CMD_CFG         8'h01
`define CMD_JOY0        8'h02
`define CMD_JOY1        8'h03
`define CMD_JOY2        8'h10
`define CMD_JOY3        8'h11
`define CMD_KBD         8'h05
`define CMD_STATUS      8'h1E
`define CMD_STATUS_REQ  8'h29

// file-io commands
`define FIO_TX          8'h53
`define FIO_TX_DAT      8'h54
`define FIO_INDEX       8'h55
`define FIO_INFO        8'h56
`define FIO_UPLOAD_KEY  8'hAA

`endif

// File: hw/hps_link_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types of the host link, imported by the blocks that use them
//////////////////////////////////////////////////////////////////////
`include "hps_link_defines.svh"

package hps_link_pkg;

	// command view of a host word
	typedef struct packed {
		logic [7:0] sub;
		logic [7:0] opcode;
	} cmd_view_t;

	// keyboard view of the same word
	typedef struct packed {
		logic [7:0] marker;
		logic [7:0] scan;
	} ps2_view_t;

	// one host bus word, decoded as a command or as a scan byte
	typedef union packed {
		cmd_view_t cmd;
		ps2_view_t ps2;
	} host_word_u;

	// word position inside a frame, 1 is the first data word
	typedef logic [`HPS_IDX_W-1:0] word_idx_t;

	// key event as seen by the core
	// toggle flips on every event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

endpackage

// File: hw/input_regs.sv
//////////////////////////////////////////////////////////////////////
// config, joystick and status registers with status request readback
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "hps_link_defines.svh"

module input_regs (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic [63:0]            status_in,
	input  logic                   status_set,
	uio_word_if.regs               uio,
	output logic [`HPS_WORD_W-1:0] cfg_word,
	output logic [31:0]            joystick_0,
	output logic [31:0]            joystick_1,
	output logic [31:0]            joystick_2,
	output logic [31:0]            joystick_3,
	output logic [63:0]            status
);
	localparam logic [7:0] JOY_CMD [`HPS_JOY_N] = '{
		`CMD_JOY0, `CMD_JOY1, `CMD_JOY2, `CMD_JOY3
	};

	logic [31:0] joy [`HPS_JOY_N];
	logic [63:0] status_req;
	logic [3:0]  req_cnt;
	logic        status_set_d;

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];

	//////////////////////////////////////////////////////////////////////
	// host writes
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cfg_word <= '0;
			status   <= '0;
			for (int j = 0; j < `HPS_JOY_N; j++) begin
				joy[j] <= '0;
			end
		end else if (uio.strobe) begin
			if (uio.cmd == `CMD_CFG) begin
				cfg_word <= uio.din;
			end
			// low half first, then high half
			for (int j = 0; j < `HPS_JOY_N; j++) begin
				if (uio.cmd == JOY_CMD[j]) begin
					if (uio.idx == 1) joy[j][15:0] <= uio.din;
					else if (uio.idx == 2) joy[j][31:16] <= uio.din;
				end
			end
			if (uio.cmd == `CMD_STATUS) begin
				case (uio.idx)
					1: status[15:0]  <= uio.din;
					2: status[31:16] <= uio.din;
					3: status[47:32] <= uio.din;
					4: status[63:48] <= uio.din;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// status request from the core
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			status_set_d <= 1'b0;
			req_cnt      <= 4'h0;
			status_req   <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				req_cnt    <= req_cnt + 1'b1;
				status_req <= status_in;
			end
		end
	end

	// readback of the captured request
	always_comb begin
		uio.reply = '0;
		if (uio.cmd == `CMD_STATUS_REQ) begin
			if (uio.cmd_valid) begin
				uio.reply = {4'hA, 8'h00, req_cnt};
			end else begin
				case (uio.idx)
					1: uio.reply = status_req[15:0];
					2: uio.reply = status_req[31:16];
					3: uio.reply = status_req[47:32];
					4: uio.reply = status_req[63:48];
					default: uio.reply = '0;
				endcase
			end
		end
	end

endmodule

// File: hw/ioctl_addr_counter.sv
//////////////////////////////////////////////////////////////////////
// download and upload address for the file transfer FSM
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "hps_link_defines.svh"

module ioctl_addr_counter (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   load_lo,
	input  logic                   load_hi,
	input  logic [15:0]            load_val,
	input  logic                   clear,
	input  logic                   step_dl,
	input  logic                   step_ul,
	input  logic                   publish,
	output logic [`HPS_ADDR_W-1:0] ioctl_addr
);
	localparam int HI_W = `HPS_ADDR_W - 16;
	localparam logic [`HPS_ADDR_W-1:0] STEP = `HPS_ADDR_STEP;

	// next write address, runs ahead of the visible one
	logic [`HPS_ADDR_W-1:0] dl_addr;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dl_addr    <= '0;
			ioctl_addr <= '0;
		end else if (clear) begin
			dl_addr    <= '0;
			ioctl_addr <= '0;
		end else if (load_lo) begin
			dl_addr[15:0]    <= load_val;
			ioctl_addr[15:0] <= load_val;
		end else if (load_hi) begin
			dl_addr[`HPS_ADDR_W-1:16]    <= load_val[HI_W-1:0];
			ioctl_addr[`HPS_ADDR_W-1:16] <= load_val[HI_W-1:0];
		end else if (step_dl) begin
			// address of the word being written
			ioctl_addr <= dl_addr;
			dl_addr    <= dl_addr + STEP;
		end else if (step_ul) begin
			ioctl_addr <= ioctl_addr + STEP;
		end else if (publish) begin
			// leave the end address visible after a download
			ioctl_addr <= dl_addr;
		end
	end

endmodule

// File: hw/ps2_key_decode.sv
//////////////////////////////////////////////////////////////////////
// turns keyboard scan-code frames into key events at frame end
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "hps_link_defines.svh"

module ps2_key_decode (
	input  logic                     clk_sys,
	input  logic                     rst,
	uio_word_if.key                  uio,
	output hps_link_pkg::key_event_t ps2_key
);
	import hps_link_pkg::*;

	// multi-byte sequences that need a fixed result
	localparam logic [31:0] PRTSCR_DOWN = 32'hE012E07C;
	localparam logic [31:0] PRTSCR_UP   = 32'h7CE0F012;
	localparam logic [31:0] PAUSE_DOWN  = 32'hF014F077;

	logic [31:0] raw;
	logic        skip;
	logic        kbd_frame;
	key_event_t  next_key;

	assign kbd_frame = (uio.cmd == `CMD_KBD);

	always_comb begin
		next_key.toggle   = ~ps2_key.toggle;
		next_key.pressed  = (raw[15:8] != 8'hF0);
		// release puts F0 between E0 and the code
		next_key.extended = next_key.pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);
		next_key.code     = raw[7:0];
		case (raw)
			PRTSCR_DOWN: {next_key.pressed, next_key.extended, next_key.code} = {2'b11, 8'h7C};
			PRTSCR_UP:   {next_key.pressed, next_key.extended, next_key.code} = {2'b01, 8'h7C};
			PAUSE_DOWN:  {next_key.pressed, next_key.extended, next_key.code} = {2'b11, 8'h77};
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			raw     <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else if (uio.frame_end) begin
			skip <= 1'b0;
			if (kbd_frame && !skip) ps2_key <= next_key;
		end else if (uio.cmd_valid && kbd_frame) begin
			raw  <= '0;
			skip <= 1'b0;
		end else if (uio.strobe && kbd_frame) begin
			if (uio.din.ps2.marker == 8'hFF) skip <= 1'b1;
			else if (!skip) raw <= {raw[23:0], uio.din.ps2.scan};
		end
	end

endmodule

// File: hw/uio_sequencer.sv
//////////////////////////////////////////////////////////////////////
// frames user-io commands and registers the reply word for the host
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "hps_link_defines.svh"

module uio_sequencer (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  logic [`HPS_WORD_W-1:0] io_din,
	uio_word_if.seq                uio,
	output logic [`HPS_WORD_W-1:0] uio_dout
);
	import hps_link_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_CMD_WAIT,
		S_DATA
	} seq_state_t;

	seq_state_t state;
	host_word_u word;
	logic [7:0] cmd_q;
	logic [7:0] cmd_code;
	word_idx_t  idx_q;
	logic       frame_end_q;
	logic       first_word;
	logic       data_word;

	assign word       = io_din;
	assign first_word = io_enable & io_strobe & (state != S_DATA);
	assign data_word  = io_enable & io_strobe & (state == S_DATA);

	// a nonzero sub byte selects nothing we implement
	assign cmd_code = (word.cmd.sub == 8'h00) ? word.cmd.opcode : 8'h00;

	assign uio.din       = word;
	assign uio.cmd_valid = first_word;
	assign uio.strobe    = data_word;
	assign uio.cmd       = first_word ? cmd_code : cmd_q;
	assign uio.idx       = idx_q;
	assign uio.frame_end = frame_end_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state       <= S_IDLE;
			cmd_q       <= 8'h00;
			idx_q       <= '0;
			frame_end_q <= 1'b0;
		end else begin
			frame_end_q <= 1'b0;
			case (state)
				S_IDLE: begin
					if (io_enable) begin
						state <= first_word ? S_DATA : S_CMD_WAIT;
						// empty frame must not replay the last command
						cmd_q <= 8'h00;
					end
				end
				S_CMD_WAIT, S_DATA: begin
					if (!io_enable) begin
						state       <= S_IDLE;
						frame_end_q <= 1'b1;
					end else if (first_word) begin
						state <= S_DATA;
					end
				end
				default: state <= S_IDLE;
			endcase
			if (first_word) begin
				cmd_q <= cmd_code;
				idx_q <= word_idx_t'(1);
			end else if (data_word && !(&idx_q)) begin
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	// reply held between strobes, zero outside frames
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			uio_dout <= '0;
		end else if (!io_enable) begin
			uio_dout <= '0;
		end else if (io_strobe) begin
			uio_dout <= uio.reply;
		end
	end

endmodule

// File: hw/uio_word_if.sv
//////////////////////////////////////////////////////////////////////
// sequenced user-io words from the sequencer to the data blocks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "hps_link_defines.svh"

interface uio_word_if;
	import hps_link_pkg::*;

	logic                   strobe;
	word_idx_t              idx;
	logic [7:0]             cmd;
	host_word_u             din;
	logic                   cmd_valid;
	logic                   frame_end;
	logic [`HPS_WORD_W-1:0] reply;

	modport seq (output strobe, idx, cmd, din, cmd_valid, frame_end, input reply);
	modport regs (input strobe, idx, cmd, din, cmd_valid, output reply);
	modport key (input strobe, cmd, din, cmd_valid, frame_end);

endinterface

// File: verification/hps_link_tb.sv
//////////////////////////////////////////////////////////////////////
// directed testbench for the host link
// drives user-io and file-io frames and checks the core side outputs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "hps_link_defines.svh"

module hps_link_tb;
	localparam int CLK_PERIOD = 8;
	localparam int N_XFER = 8;
	// a strobed word takes two cycles and a frame about five more
	localparam int N_WORDS = 50 + 2 * N_XFER;
	localparam int N_FRAMES = 18;
	localparam int TEST_CYCLES = 2 * N_WORDS + 5 * N_FRAMES + 16;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;
	localparam logic [7:0] JOY_CMD [4] = '{`CMD_JOY0, `CMD_JOY1, `CMD_JOY2, `CMD_JOY3};

	logic        clk_sys;
	logic        rst;
	logic        io_enable;
	logic        fp_enable;
	logic        io_strobe;
	logic [15:0] io_din;
	logic [63:0] status_in;
	logic        status_set;
	logic [7:0]  ioctl_din;
	logic        ioctl_wait;
	logic [15:0] io_dout;
	logic        hps_wait;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic [31:0] joystick_2;
	logic [31:0] joystick_3;
	logic [63:0] status;
	logic [10:0] ps2_key;
	logic        ioctl_download;
	logic        ioctl_upload;
	logic [15:0] ioctl_index;
	logic [31:0] ioctl_file_ext;
	logic [26:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_rd;

	int          seed = 94;
	int          cycle = 0;
	int          check_count = 0;
	int          error_count = 0;
	// words of the next frame and what came back per word
	logic [15:0] words [$];
	logic [7:0]  mem_bytes [$];
	logic [15:0] replies [$];
	logic        rd_seen [$];
	logic [26:0] addr_seen [$];
	int          stb_cycles [$];
	// write pulses seen on the memory side
	int          wr_cycles [$];
	logic [26:0] wr_addr [$];
	logic [7:0]  wr_data [$];

	hps_link u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) cycle <= cycle + 1;

	always @(negedge clk_sys) begin
		if (ioctl_wr) begin
			wr_cycles.push_back(cycle);
			wr_addr.push_back(ioctl_addr);
			wr_data.push_back(ioctl_dout);
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic new_frame(input logic [7:0] cmd);
		words.delete();
		words.push_back({8'h00, cmd});
	endtask

	task automatic clear_records();
		replies.delete();
		rd_seen.delete();
		addr_seen.delete();
		stb_cycles.delete();
	endtask

	// entered and left on a falling edge
	task automatic strobe_word(input logic [15:0] w, input logic [7:0] mem_byte);
		@(posedge clk_sys);
		io_din    <= w;
		io_strobe <= 1'b1;
		ioctl_din <= mem_byte;
		@(negedge clk_sys);
		stb_cycles.push_back(cycle);
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(negedge clk_sys);
		replies.push_back(io_dout);
		rd_seen.push_back(ioctl_rd);
		addr_seen.push_back(ioctl_addr);
	endtask

	task automatic send_uio_frame();
		clear_records();
		@(posedge clk_sys);
		io_enable <= 1'b1;
		foreach (words[i]) strobe_word(words[i], 8'h00);
		@(posedge clk_sys);
		io_enable <= 1'b0;
		// frame end plus the key register behind it
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic send_fio_frame();
		clear_records();
		@(posedge clk_sys);
		fp_enable <= 1'b1;
		foreach (words[i]) begin
			strobe_word(words[i], (i < mem_bytes.size()) ? mem_bytes[i] : 8'h00);
		end
		@(posedge clk_sys);
		fp_enable <= 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic after_reset_check();
		check_value("io_dout", 64'(io_dout), 64'h0);
		check_value("ioctl_wr", 64'(ioctl_wr), 64'h0);
		check_value("ioctl_rd", 64'(ioctl_rd), 64'h0);
		check_value("ioctl_download", 64'(ioctl_download), 64'h0);
		check_value("ioctl_upload", 64'(ioctl_upload), 64'h0);
		check_value("ps2_key", 64'(ps2_key), 64'h0);
		@(posedge clk_sys);
		ioctl_wait <= 1'b1;
		@(negedge clk_sys);
		check_value("hps_wait", 64'(hps_wait), 64'h1);
		@(posedge clk_sys);
		ioctl_wait <= 1'b0;
		@(negedge clk_sys);
		check_value("hps_wait", 64'(hps_wait), 64'h0);
	endtask

	task automatic config_and_joysticks();
		logic [15:0] w;
		logic [15:0] lo;
		logic [15:0] hi;
		logic [31:0] joy_exp [4];
		w = 16'($random(seed));
		new_frame(`CMD_CFG);
		words.push_back(w);
		send_uio_frame();
		check_value("buttons", 64'(buttons), 64'(w[1:0]));
		check_value("forced_scandoubler", 64'(forced_scandoubler), 64'(w[4]));
		check_value("direct_video", 64'(direct_video), 64'(w[10]));
		for (int j = 0; j < 4; j++) joy_exp[j] = '0;
		for (int j = 0; j < 4; j++) begin
			lo = 16'($random(seed));
			hi = 16'($random(seed));
			new_frame(JOY_CMD[j]);
			words.push_back(lo);
			words.push_back(hi);
			send_uio_frame();
			joy_exp[j] = {hi, lo};
			check_value("joystick_0", 64'(joystick_0), 64'(joy_exp[0]));
			check_value("joystick_1", 64'(joystick_1), 64'(joy_exp[1]));
			check_value("joystick_2", 64'(joystick_2), 64'(joy_exp[2]));
			check_value("joystick_3", 64'(joystick_3), 64'(joy_exp[3]));
		end
	endtask

	task automatic status_write_and_request();
		logic [63:0] stat_exp;
		logic [63:0] req_val;
		logic [15:0] part;
		new_frame(`CMD_STATUS);
		for (int h = 0; h < 4; h++) begin
			part = 16'($random(seed));
			words.push_back(part);
			stat_exp[h*16 +: 16] = part;
		end
		send_uio_frame();
		check_value("status", status, stat_exp);
		// two rising edges with the last sample held on status_in
		for (int n = 0; n < 2; n++) begin
			@(posedge clk_sys);
			req_val = {$random(seed), $random(seed)};
			status_in  <= req_val;
			status_set <= 1'b1;
			@(posedge clk_sys);
			status_set <= 1'b0;
		end
		new_frame(`CMD_STATUS_REQ);
		repeat (4) words.push_back(16'h0000);
		send_uio_frame();
		check_value("io_dout", 64'(replies[0]), 64'({4'hA, 8'h00, 4'd2}));
		for (int h = 0; h < 4; h++) begin
			check_value("io_dout", 64'(replies[h+1]), 64'(req_val[h*16 +: 16]));
		end
	endtask

	task automatic keyboard_events();
		logic [7:0]  code;
		logic [10:0] key_exp;
		key_exp = '0;
		code = 8'($random(seed));
		new_frame(`CMD_KBD);
		words.push_back({8'h00, code});
		send_uio_frame();
		key_exp = {~key_exp[10], 1'b1, 1'b0, code};
		check_value("ps2_key", 64'(ps2_key), 64'(key_exp));
		// extended key release
		code = 8'($random(seed));
		new_frame(`CMD_KBD);
		words.push_back(16'h00E0);
		words.push_back(16'h00F0);
		words.push_back({8'h00, code});
		send_uio_frame();
		key_exp = {~key_exp[10], 1'b0, 1'b1, code};
		check_value("ps2_key", 64'(ps2_key), 64'(key_exp));
		new_frame(`CMD_KBD);
		words.push_back(16'h001C);
		words.push_back(16'hFF00);
		send_uio_frame();
		check_value("ps2_key", 64'(ps2_key), 64'(key_exp));
	endtask

	task automatic file_download();
		logic [15:0] index;
		logic [31:0] ext;
		logic [15:0] base;
		index = 16'($random(seed));
		ext   = $random(seed);
		new_frame(`FIO_INDEX);
		words.push_back(index);
		send_fio_frame();
		check_value("ioctl_index", 64'(ioctl_index), 64'(index));
		new_frame(`FIO_INFO);
		words.push_back(ext[31:16]);
		words.push_back(ext[15:0]);
		send_fio_frame();
		check_value("ioctl_file_ext", 64'(ioctl_file_ext), 64'(ext));
		base = 16'($random(seed));
		new_frame(`FIO_TX);
		words.push_back(16'h0001);
		words.push_back(base);
		send_fio_frame();
		check_value("ioctl_download", 64'(ioctl_download), 64'h1);
		wr_cycles.delete();
		wr_addr.delete();
		wr_data.delete();
		new_frame(`FIO_TX_DAT);
		for (int i = 0; i < N_XFER; i++) words.push_back(16'($random(seed)));
		send_fio_frame();
		check_count++;
		assert (wr_cycles.size() == N_XFER) else begin
			error_count++;
			$display("download gave %0d write pulses for %0d data words",
				wr_cycles.size(), N_XFER);
		end
		for (int i = 0; i < N_XFER && i < wr_cycles.size(); i++) begin
			check_value("ioctl_wr cycle", 64'(wr_cycles[i]), 64'(stb_cycles[i+1] + 2));
			check_value("ioctl_addr", 64'(wr_addr[i]), 64'(base) + 64'(i));
			check_value("ioctl_dout", 64'(wr_data[i]), 64'(words[i+1][7:0]));
		end
		new_frame(`FIO_TX);
		words.push_back(16'h0000);
		send_fio_frame();
		check_value("ioctl_download", 64'(ioctl_download), 64'h0);
		// end address stays visible once the download is over
		check_value("ioctl_addr", 64'(ioctl_addr), 64'(base) + 64'(N_XFER));
	endtask

	task automatic file_upload();
		logic [15:0] base;
		base = 16'($random(seed));
		new_frame(`FIO_TX);
		words.push_back({8'h00, `FIO_UPLOAD_KEY});
		words.push_back(base);
		send_fio_frame();
		check_value("ioctl_upload", 64'(ioctl_upload), 64'h1);
		check_value("ioctl_rd", 64'(rd_seen[1]), 64'h1);
		// first byte slot lines up with the command word
		new_frame(`FIO_TX_DAT);
		mem_bytes.push_back(8'h00);
		for (int i = 0; i < N_XFER; i++) begin
			words.push_back(16'h0000);
			mem_bytes.push_back(8'($random(seed)));
		end
		send_fio_frame();
		for (int i = 0; i < N_XFER; i++) begin
			check_value("io_dout", 64'(replies[i+1]), 64'({8'h00, mem_bytes[i+1]}));
			check_value("ioctl_rd", 64'(rd_seen[i+1]), 64'h1);
			check_value("ioctl_addr", 64'(addr_seen[i+1]), 64'(base) + 64'(i + 1));
		end
		mem_bytes.delete();
		new_frame(`FIO_TX);
		words.push_back(16'h0000);
		send_fio_frame();
		check_value("ioctl_upload", 64'(ioctl_upload), 64'h0);
	endtask

	initial begin
		rst        = 1'b1;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_din  = '0;
		ioctl_wait = 1'b0;
		repeat (3) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		after_reset_check();
		config_and_joysticks();
		status_write_and_request();
		keyboard_events();
		file_download();
		file_upload();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
